/* common/mipsPkg.sv */
package mipsPkg;

	// First fetch address out of reset
	localparam logic [31:0] RESET_PC = 32'h0000_3000;

	////////////////////////////////////////////////////////////
	// Instruction encodings

	typedef enum logic [5:0] {
		SPECIAL = 6'b000000,
		J       = 6'b000010,
		JAL     = 6'b000011,
		BEQ     = 6'b000100,
		ORI     = 6'b001101,
		LUI     = 6'b001111,
		LW      = 6'b100011,
		SB      = 6'b101000,
		SW      = 6'b101011
	} opcodeE;

	typedef enum logic [5:0] {
		JR   = 6'b001000,
		ADDU = 6'b100001,
		SUBU = 6'b100011
	} functE;

	////////////////////////////////////////////////////////////
	// Control encodings

	typedef enum logic [1:0] {
		ADD,
		SUB,
		OR,
		LUI_SHIFT
	} aluOpE;

	typedef enum logic [1:0] {
		SEQ,    // PC+4
		BRANCH, // beq, if taken
		JUMP,   // j / jal region jump
		JREG    // jr
	} npcOpE;

	typedef enum logic [1:0] {
		ALU,
		MEM,
		LINK
	} wbSelE;

	// All-zero value is a no-op bubble
	typedef struct packed {
		aluOpE       aluOp;
		logic        immB;      // Immediate replaces rt as operand B
		logic        signExt;
		npcOpE       npcOp;
		logic        isBranch;
		logic        regWrite;
		logic [4:0]  dest;
		logic        memWrite;
		logic        byteStore;
		logic        memRead;
		wbSelE       wbSel;
		logic        usesRs;
		logic        usesRt;
	} ctrlT;

	////////////////////////////////////////////////////////////
	// Pipeline registers

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fdRegT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		ctrlT        ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [15:0] imm;
	} deRegT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [31:0] result;    // ALU result or link address
		logic [31:0] storeVal;
		logic [4:0]  rtNum;     // For late store-data forwarding
	} emRegT;

	typedef struct packed {
		logic [31:0] pc;
		ctrlT        ctrl;
		logic [31:0] result;
		logic [31:0] loadVal;
	} mwRegT;

endpackage

/* decode/ctrl.sv */
`timescale 1ns/1ps

module ctrl (
	input  logic [31:0]   instr,
	output mipsPkg::ctrlT ctrl
);
	import mipsPkg::*;

	opcodeE     op;
	functE      funct;
	logic [4:0] rt;
	logic [4:0] rd;

	assign op    = opcodeE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];

	always_comb begin
		ctrl = '0;   // Anything unmatched stays a no-op
		case (op)
			SPECIAL: begin
				case (funct)
					ADDU, SUBU: begin
						ctrl.aluOp    = (funct == SUBU) ? SUB : ADD;
						ctrl.regWrite = 1'b1;
						ctrl.dest     = rd;
						ctrl.usesRs   = 1'b1;
						ctrl.usesRt   = 1'b1;
					end
					JR: begin
						ctrl.npcOp  = JREG;
						ctrl.usesRs = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			ORI, LUI: begin
				ctrl.aluOp    = (op == LUI) ? LUI_SHIFT : OR;
				ctrl.immB     = 1'b1;   // Zero extended
				ctrl.regWrite = 1'b1;
				ctrl.dest     = rt;
				ctrl.usesRs   = (op == ORI);
			end
			LW: begin
				ctrl.immB     = 1'b1;
				ctrl.signExt  = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest     = rt;
				ctrl.wbSel    = MEM;
				ctrl.usesRs   = 1'b1;
			end
			SW, SB: begin
				ctrl.immB      = 1'b1;
				ctrl.signExt   = 1'b1;
				ctrl.memWrite  = 1'b1;
				ctrl.byteStore = (op == SB);
				ctrl.usesRs    = 1'b1;
				ctrl.usesRt    = 1'b1;   // Store data
			end
			BEQ: begin
				ctrl.npcOp    = BRANCH;
				ctrl.isBranch = 1'b1;
				ctrl.usesRs   = 1'b1;
				ctrl.usesRt   = 1'b1;
			end
			J:   ctrl.npcOp = JUMP;
			JAL: begin
				ctrl.npcOp    = JUMP;
				ctrl.regWrite = 1'b1;
				ctrl.dest     = 5'd31;
				ctrl.wbSel    = LINK;
			end
			default: ctrl = '0;
		endcase

		// Writes to $0 are dropped here
		if (ctrl.dest == 5'd0)
			ctrl.regWrite = 1'b0;
	end

endmodule

/* decode/grf.sv */
`timescale 1ns/1ps

module grf (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  logic [4:0]  wAddr,
	input  logic [31:0] wData,
	input  logic [4:0]  rAddr1,
	input  logic [4:0]  rAddr2,
	output logic [31:0] rData1,
	output logic [31:0] rData2
);

	logic [31:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (we && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// Writeback bypass so decode sees this cycle's write
	assign rData1 = (rAddr1 == 5'd0) ? 32'd0 :
		(we && wAddr == rAddr1) ? wData : regs[rAddr1];
	assign rData2 = (rAddr2 == 5'd0) ? 32'd0 :
		(we && wAddr == rAddr2) ? wData : regs[rAddr2];

endmodule

/* src/ifu.sv */
`timescale 1ns/1ps

module ifu (
	input  logic           clk,
	input  logic           rst,
	input  logic           stall,
	input  mipsPkg::npcOpE npcOp,
	input  logic           taken,
	input  logic [15:0]    offset,
	input  logic [25:0]    index,
	input  logic [31:0]    regTarget,
	input  logic [31:0]    pcD,
	output logic [31:0]    pc
);
	import mipsPkg::*;

	logic [31:0] seqD;   // Delay slot address, base for targets
	logic [31:0] npc;

	assign seqD = pcD + 32'd4;

	// Decode-stage control flow picks the next fetch
	always_comb begin
		npc = pc + 32'd4;
		case (npcOp)
			BRANCH: begin
				if (taken)
					npc = seqD + {{14{offset[15]}}, offset, 2'b00};
			end
			JUMP:    npc = {seqD[31:28], index, 2'b00};
			JREG:    npc = regTarget;
			default: npc = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (!stall)
			pc <= npc;   // Hold on load-use or branch stall
	end

endmodule

/* src/hazard.sv */
`timescale 1ns/1ps

module hazard (
	input  mipsPkg::ctrlT dCtrl,
	input  logic [4:0]    rsD,
	input  logic [4:0]    rtD,
	input  mipsPkg::ctrlT eCtrl,
	output logic          stall
);
	import mipsPkg::*;

	logic eWrites;
	logic rsHit;
	logic rtHit;
	logic eLoad;
	logic eAluLate;
	logic dEarly;

	////////////////////////////////////////////////////////////
	// Operand matches against the execute stage

	assign eWrites = eCtrl.regWrite && (eCtrl.dest != 5'd0);   // $0 never stalls

	assign rsHit = dCtrl.usesRs && (rsD == eCtrl.dest);
	assign rtHit = dCtrl.usesRt && (rtD == eCtrl.dest);

	////////////////////////////////////////////////////////////
	// Result readiness

	// Load data only exists once the load is in M
	assign eLoad = eWrites && eCtrl.memRead;

	// ALU value still being computed, too late for a decode compare
	assign eAluLate = eWrites && (eCtrl.wbSel == ALU);

	// beq and jr need their operands in decode
	assign dEarly = dCtrl.isBranch || (dCtrl.npcOp == JREG);

	// One cycle is always enough: afterwards the producer sits in M
	assign stall = (eLoad || (dEarly && eAluLate)) && (rsHit || rtHit);

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
	input  mipsPkg::ctrlT ctrl,
	input  logic [31:0]   srcA,
	input  logic [31:0]   rtVal,
	input  logic [15:0]   imm,
	output logic [31:0]   result
);
	import mipsPkg::*;

	logic [31:0] immExt;
	logic [31:0] srcB;

	assign immExt = ctrl.signExt ? {{16{imm[15]}}, imm} : {16'd0, imm};
	assign srcB   = ctrl.immB ? immExt : rtVal;

	always_comb begin
		case (ctrl.aluOp)
			ADD:       result = srcA + srcB;   // addu, address calc
			SUB:       result = srcA - srcB;
			OR:        result = srcA | srcB;
			LUI_SHIFT: result = {srcB[15:0], 16'd0};
			default:   result = srcA + srcB;
		endcase
	end

endmodule

/* src/mips.sv */
`timescale 1ns/1ps

module mips (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] iInstRdata,
	input  logic [31:0] mDataRdata,
	output logic [31:0] iInstAddr,
	output logic [31:0] mDataAddr,
	output logic [31:0] mDataWdata,
	output logic [3:0]  mDataByteen,
	output logic [31:0] mInstAddr,
	output logic        wGrfWe,
	output logic [4:0]  wGrfAddr,
	output logic [31:0] wGrfWdata,
	output logic [31:0] wInstAddr
);
	import mipsPkg::*;

	fdRegT fdReg;
	deRegT deReg;
	emRegT emReg;
	mwRegT mwReg;

	logic        stall;
	logic [31:0] pcF;
	ctrlT        ctrlD;
	logic [4:0]  rsD;
	logic [4:0]  rtD;
	logic [31:0] grfRs;
	logic [31:0] grfRt;
	logic [31:0] rsValD;
	logic [31:0] rtValD;
	logic [31:0] mFwd;
	logic [31:0] linkE;
	logic [4:0]  rsE;
	logic [4:0]  rtE;
	logic [31:0] srcAE;
	logic [31:0] rtValE;
	logic [31:0] aluOutE;
	logic [31:0] resultE;
	logic [31:0] storeM;

	// Stage c writes register num
	function automatic logic hits(input ctrlT c, input logic [4:0] num);
		return c.regWrite && (c.dest != 5'd0) && (c.dest == num);
	endfunction

	////////////////////////////////////////////////////////////
	// Fetch

	ifu uIfu (
		.clk       (clk),
		.rst       (rst),
		.stall     (stall),
		.npcOp     (ctrlD.npcOp),
		.taken     (rsValD == rtValD),
		.offset    (fdReg.instr[15:0]),
		.index     (fdReg.instr[25:0]),
		.regTarget (rsValD),
		.pcD       (fdReg.pc),
		.pc        (pcF)
	);

	assign iInstAddr = pcF;

	always_ff @(posedge clk) begin
		if (rst)
			fdReg <= '0;
		else if (!stall)
			fdReg <= '{pc: pcF, instr: iInstRdata};
	end

	////////////////////////////////////////////////////////////
	// Decode

	assign rsD = fdReg.instr[25:21];
	assign rtD = fdReg.instr[20:16];

	ctrl uCtrl (.instr(fdReg.instr), .ctrl(ctrlD));

	grf uGrf (
		.clk    (clk),
		.rst    (rst),
		.we     (wGrfWe),
		.wAddr  (wGrfAddr),
		.wData  (wGrfWdata),
		.rAddr1 (rsD),
		.rAddr2 (rtD),
		.rData1 (grfRs),
		.rData2 (grfRt)
	);

	// Load data comes straight from the combinational memory read
	assign mFwd  = (emReg.ctrl.wbSel == MEM) ? mDataRdata : emReg.result;
	assign linkE = deReg.pc + 32'd8;   // jal in E

	// Youngest producer first
	assign rsValD = (hits(deReg.ctrl, rsD) && deReg.ctrl.wbSel == LINK) ? linkE :
		hits(emReg.ctrl, rsD) ? mFwd : grfRs;
	assign rtValD = (hits(deReg.ctrl, rtD) && deReg.ctrl.wbSel == LINK) ? linkE :
		hits(emReg.ctrl, rtD) ? mFwd : grfRt;

	hazard uHazard (
		.dCtrl (ctrlD),
		.rsD   (rsD),
		.rtD   (rtD),
		.eCtrl (deReg.ctrl),
		.stall (stall)
	);

	always_ff @(posedge clk) begin
		if (rst || stall)
			deReg <= '0;   // Bubble
		else
			deReg <= '{pc: fdReg.pc, instr: fdReg.instr, ctrl: ctrlD,
				rsVal: rsValD, rtVal: rtValD, imm: fdReg.instr[15:0]};
	end

	////////////////////////////////////////////////////////////
	// Execute

	assign rsE = deReg.instr[25:21];
	assign rtE = deReg.instr[20:16];

	assign srcAE  = hits(emReg.ctrl, rsE) ? mFwd :
		hits(mwReg.ctrl, rsE) ? wGrfWdata : deReg.rsVal;
	assign rtValE = hits(emReg.ctrl, rtE) ? mFwd :
		hits(mwReg.ctrl, rtE) ? wGrfWdata : deReg.rtVal;

	alu uAlu (
		.ctrl   (deReg.ctrl),
		.srcA   (srcAE),
		.rtVal  (rtValE),
		.imm    (deReg.imm),
		.result (aluOutE)
	);

	assign resultE = (deReg.ctrl.wbSel == LINK) ? linkE : aluOutE;

	always_ff @(posedge clk) begin
		if (rst)
			emReg <= '0;
		else
			emReg <= '{pc: deReg.pc, ctrl: deReg.ctrl, result: resultE,
				storeVal: rtValE, rtNum: rtE};
	end

	////////////////////////////////////////////////////////////
	// Memory

	assign storeM     = hits(mwReg.ctrl, emReg.rtNum) ? wGrfWdata : emReg.storeVal;
	assign mDataAddr  = emReg.result;
	assign mDataWdata = emReg.ctrl.byteStore ? {4{storeM[7:0]}} : storeM;
	assign mInstAddr  = emReg.pc;

	always_comb begin
		if (!emReg.ctrl.memWrite)
			mDataByteen = 4'b0000;
		else if (emReg.ctrl.byteStore)
			mDataByteen = 4'b0001 << emReg.result[1:0];   // One lane for sb
		else
			mDataByteen = 4'b1111;
	end

	always_ff @(posedge clk) begin
		if (rst)
			mwReg <= '0;
		else
			mwReg <= '{pc: emReg.pc, ctrl: emReg.ctrl, result: emReg.result,
				loadVal: mDataRdata};
	end

	////////////////////////////////////////////////////////////
	// Writeback

	always_comb begin
		case (mwReg.ctrl.wbSel)
			MEM:     wGrfWdata = mwReg.loadVal;
			LINK:    wGrfWdata = mwReg.pc + 32'd8;
			default: wGrfWdata = mwReg.result;
		endcase
	end

	assign wGrfWe    = mwReg.ctrl.regWrite;
	assign wGrfAddr  = mwReg.ctrl.dest;
	assign wInstAddr = mwReg.pc;

endmodule

/* verification/mips_asserts.sv */
`timescale 1ns/1ps

module mips_asserts (
	input logic        clk,
	input logic        rst,
	input logic        stall,
	input logic [31:0] iInstAddr,
	input logic        wGrfWe,
	input logic [4:0]  wGrfAddr,
	input logic [31:0] wGrfWdata,
	input logic [3:0]  mDataByteen
);

	int failCount = 0;

	// $0 stays zero at the write port
	zeroRegWrite: assert property (@(posedge clk) disable iff (rst)
		!(wGrfWe && wGrfAddr == 5'd0 && wGrfWdata != 32'd0))
		else begin
			failCount++;
			$error("Nonzero value written to register 0");
		end

	fetchHolds: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(iInstAddr))   // PC frozen for the stall cycle
		else begin
			failCount++;
			$error("Fetch address moved during a stall");
		end

	// Pipe still filling with bubbles
	quietAfterReset: assert property (@(posedge clk)
		$fell(rst) |-> (mDataByteen == 4'b0000) [*4])
		else begin
			failCount++;
			$error("Store strobe active right after reset");
		end

endmodule

bind mips mips_asserts uAsserts (
	.clk         (clk),
	.rst         (rst),
	.stall       (stall),
	.iInstAddr   (iInstAddr),
	.wGrfWe      (wGrfWe),
	.wGrfAddr    (wGrfAddr),
	.wGrfWdata   (wGrfWdata),
	.mDataByteen (mDataByteen)
);

/* verification/tbMips.sv */
`timescale 1ns/1ps

module tbMips;
	import mipsPkg::*;

	// Program lengths of the five tests
	localparam int TEST_INSTRS = 4 + 12 + 4 + 14 + 19;
	localparam int RUN_LIMIT   = TEST_INSTRS * 3 + 100;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  num;
		logic [31:0] val;
	} wbRecT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] addr;
		logic [3:0]  byteen;
		logic [31:0] data;
	} stRecT;

	logic        clk;
	logic        rst;
	logic [31:0] iInstRdata;
	logic [31:0] mDataRdata;
	logic [31:0] iInstAddr;
	logic [31:0] mDataAddr;
	logic [31:0] mDataWdata;
	logic [3:0]  mDataByteen;
	logic [31:0] mInstAddr;
	logic        wGrfWe;
	logic [4:0]  wGrfAddr;
	logic [31:0] wGrfWdata;
	logic [31:0] wInstAddr;

	logic [31:0] imem [0:1023];
	logic [31:0] dmem [0:1023];
	logic [31:0] modelMem [0:1023];   // Sequential model's view of data memory
	logic [31:0] prog [$];
	wbRecT       wbExp [$];
	wbRecT       wbSeen [$];
	int          wbCycle [$];
	stRecT       stExp [$];
	stRecT       stSeen [$];
	logic [31:0] lcgState;
	int cycles = 0;
	int errors;
	int checks;
	int tests;
	int errStart;
	int checkStart;
	int modelSteps;

	mips u_dut (
		.clk         (clk),
		.rst         (rst),
		.iInstRdata  (iInstRdata),
		.mDataRdata  (mDataRdata),
		.iInstAddr   (iInstAddr),
		.mDataAddr   (mDataAddr),
		.mDataWdata  (mDataWdata),
		.mDataByteen (mDataByteen),
		.mInstAddr   (mInstAddr),
		.wGrfWe      (wGrfWe),
		.wGrfAddr    (wGrfAddr),
		.wGrfWdata   (wGrfWdata),
		.wInstAddr   (wInstAddr)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Memories and monitors

	function automatic logic [31:0] fillWord(input int i);
		logic [11:0] a;
		a = 12'(i * 4);
		return {4'hc, a, 4'h5, a};   // Byte address appears twice
	endfunction

	assign iInstRdata = imem[iInstAddr[11:2]];
	assign mDataRdata = dmem[mDataAddr[11:2]];

	// Data memory refills while rst is high
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 1024; i++)
				dmem[i] <= fillWord(i);
		end else begin
			for (int b = 0; b < 4; b++)
				if (mDataByteen[b])
					dmem[mDataAddr[11:2]][8*b +: 8] <= mDataWdata[8*b +: 8];
		end
	end

	// Sampled mid-cycle when outputs are settled
	always @(negedge clk) begin
		if (!rst && wGrfWe) begin
			wbSeen.push_back({wInstAddr, wGrfAddr, wGrfWdata});
			wbCycle.push_back(cycles);
		end
		if (!rst && mDataByteen != 4'b0000)
			stSeen.push_back({mInstAddr, mDataAddr, mDataByteen, mDataWdata});
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= RUN_LIMIT) begin
			$display("Run stopped by timeout after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Assembler and reference model

	function automatic logic [31:0] rInst(input functE f, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {SPECIAL, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic logic [31:0] iInst(input opcodeE op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jInst(input opcodeE op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	function automatic logic [31:0] instAddr(input int i);
		return RESET_PC + 32'(4 * i);
	endfunction

	function automatic logic [15:0] randImm();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// Runs the program one instruction at a time including delay slots
	task automatic runModel(input logic [31:0] stopPc);
		logic [31:0] regs [0:31];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nnpc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] addr;
		logic [31:0] val;
		logic [4:0]  dst;
		logic [1:0]  lane;
		for (int i = 0; i < 32; i++)
			regs[i] = 32'd0;
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		modelSteps = 0;
		while (pc != stopPc && modelSteps < 200) begin
			ins  = imem[pc[11:2]];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			addr = a + sImm;
			nnpc = npc + 32'd4;
			dst  = 5'd0;
			val  = 32'd0;
			case (ins[31:26])
				SPECIAL: begin
					if (ins[5:0] == ADDU || ins[5:0] == SUBU) begin
						dst = ins[15:11];
						val = (ins[5:0] == ADDU) ? a + b : a - b;
					end else if (ins[5:0] == JR) begin
						nnpc = a;
					end
				end
				ORI: begin
					dst = ins[20:16];
					val = a | {16'd0, ins[15:0]};
				end
				LUI: begin
					dst = ins[20:16];
					val = {ins[15:0], 16'd0};
				end
				LW: begin
					dst = ins[20:16];
					val = modelMem[addr[11:2]];
				end
				SW: begin
					modelMem[addr[11:2]] = b;
					stExp.push_back({pc, addr, 4'b1111, b});
				end
				SB: begin
					lane = addr[1:0];
					modelMem[addr[11:2]][8*lane +: 8] = b[7:0];
					stExp.push_back({pc, addr, 4'b0001 << lane, {4{b[7:0]}}});
				end
				BEQ: begin
					if (a == b)
						nnpc = npc + (sImm << 2);
				end
				J:       nnpc = {npc[31:28], ins[25:0], 2'b00};
				JAL: begin
					nnpc = {npc[31:28], ins[25:0], 2'b00};
					dst = 5'd31;
					val = pc + 32'd8;   // Return past the delay slot
				end
				default: ;
			endcase
			if (dst != 5'd0) begin
				regs[dst] = val;
				wbExp.push_back({pc, dst, val});
			end
			pc = npc;
			npc = nnpc;
			modelSteps++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequencing

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		wbSeen.delete();
		wbCycle.delete();
		stSeen.delete();
		@(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic startTest(input int stopIdx);
		for (int i = 0; i < 1024; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
			modelMem[i] = fillWord(i);
		end
		wbExp.delete();
		stExp.delete();
		errStart = errors;
		checkStart = checks;
		runModel(instAddr(stopIdx));
		applyReset();
	endtask

	task automatic awaitResults();
		int waited;
		waited = 0;
		while ((wbSeen.size() < wbExp.size() || stSeen.size() < stExp.size())
			&& waited < modelSteps * 3 + 20) begin
			@(posedge clk);
			waited++;
		end
		if (waited >= modelSteps * 3 + 20) begin
			errors++;
			$display("DUT stopped short: %0d of %0d writebacks, %0d of %0d stores",
				wbSeen.size(), wbExp.size(), stSeen.size(), stExp.size());
		end
		repeat (6) @(posedge clk);   // Let any extra writes show up
	endtask

	task automatic reportTest(input string name);
		int n;
		checks += 2;
		if (wbSeen.size() != wbExp.size()) begin
			errors++;
			$display("FAILED %s writeback count: expected %0d, actual %0d",
				name, wbExp.size(), wbSeen.size());
		end
		if (stSeen.size() != stExp.size()) begin
			errors++;
			$display("FAILED %s store count: expected %0d, actual %0d",
				name, stExp.size(), stSeen.size());
		end
		n = (wbSeen.size() < wbExp.size()) ? wbSeen.size() : wbExp.size();
		for (int i = 0; i < n; i++) begin
			checks++;
			if (wbSeen[i] !== wbExp[i]) begin
				errors++;
				$display("FAILED %s writeback %0d: expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
					name, i, wbExp[i].pc, wbExp[i].num, wbExp[i].val,
					wbSeen[i].pc, wbSeen[i].num, wbSeen[i].val);
			end
		end
		n = (stSeen.size() < stExp.size()) ? stSeen.size() : stExp.size();
		for (int i = 0; i < n; i++) begin
			checks++;
			if (stSeen[i] !== stExp[i]) begin
				errors++;
				$display("FAILED %s store %0d: expected pc=%h %h/%b/%h, actual pc=%h %h/%b/%h",
					name, i, stExp[i].pc, stExp[i].addr, stExp[i].byteen, stExp[i].data,
					stSeen[i].pc, stSeen[i].addr, stSeen[i].byteen, stSeen[i].data);
			end
		end
		tests++;
		$display("%s: %0d checks, %0d errors", name, checks - checkStart, errors - errStart);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic resetIdle();
		prog.delete();
		prog.push_back(iInst(ORI, 5'd0, 5'd1, randImm()));
		prog.push_back(iInst(SW, 5'd0, 5'd1, 16'h0010));
		prog.push_back(rInst(ADDU, 5'd1, 5'd1, 5'd2));
		prog.push_back(iInst(SB, 5'd0, 5'd2, 16'h0013));
		startTest(prog.size());
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			checks += 2;
			if (k == 0 && iInstAddr !== RESET_PC) begin
				errors++;
				$display("FAILED resetIdle fetch address: expected %h, actual %h",
					RESET_PC, iInstAddr);
			end
			if (wGrfWe !== 1'b0 || mDataByteen !== 4'b0000) begin
				errors++;
				$display("resetIdle: a write or store appeared %0d cycles after reset", k);
			end
		end
		awaitResults();
		reportTest("resetIdle");
	endtask

	task automatic aluChain();
		prog.delete();
		prog.push_back(iInst(ORI, 5'd0, 5'd1, randImm()));
		prog.push_back(iInst(LUI, 5'd0, 5'd2, randImm()));
		prog.push_back(rInst(ADDU, 5'd1, 5'd2, 5'd3));   // E/M and W paths
		prog.push_back(rInst(SUBU, 5'd3, 5'd1, 5'd4));
		prog.push_back(iInst(ORI, 5'd4, 5'd5, randImm()));
		prog.push_back(rInst(ADDU, 5'd5, 5'd5, 5'd6));
		prog.push_back(iInst(LUI, 5'd0, 5'd7, randImm()));
		prog.push_back(rInst(SUBU, 5'd7, 5'd6, 5'd8));
		prog.push_back(iInst(ORI, 5'd8, 5'd9, randImm()));
		prog.push_back(rInst(ADDU, 5'd9, 5'd3, 5'd1));   // $3 from the register file
		prog.push_back(rInst(SUBU, 5'd1, 5'd9, 5'd2));
		prog.push_back(iInst(ORI, 5'd2, 5'd10, randImm()));
		startTest(prog.size());
		awaitResults();
		reportTest("aluChain");
	endtask

	task automatic loadUse();
		prog.delete();
		prog.push_back(iInst(ORI, 5'd0, 5'd1, randImm()));
		prog.push_back(iInst(LW, 5'd0, 5'd2, 16'h0040));
		prog.push_back(rInst(ADDU, 5'd2, 5'd1, 5'd3));
		prog.push_back(rInst(SUBU, 5'd3, 5'd2, 5'd4));
		startTest(prog.size());
		awaitResults();
		if (wbCycle.size() == 4) begin
			checks++;
			// The dependent addu trails the load by one bubble
			if (wbCycle[2] - wbCycle[1] != 2 || wbCycle[3] - wbCycle[2] != 1) begin
				errors++;
				$display("FAILED loadUse writeback spacing: expected 2,1, actual %0d,%0d",
					wbCycle[2] - wbCycle[1], wbCycle[3] - wbCycle[2]);
			end
		end
		reportTest("loadUse");
	endtask

	task automatic storeLanes();
		prog.delete();
		prog.push_back(iInst(LUI, 5'd0, 5'd1, randImm()));
		prog.push_back(iInst(ORI, 5'd1, 5'd1, randImm()));
		prog.push_back(iInst(ORI, 5'd0, 5'd2, 16'h0080));
		prog.push_back(iInst(SW, 5'd2, 5'd1, 16'h0000));
		prog.push_back(rInst(ADDU, 5'd1, 5'd1, 5'd4));
		prog.push_back(iInst(SB, 5'd2, 5'd4, 16'h0020));   // Store data from M
		prog.push_back(iInst(SB, 5'd2, 5'd1, 16'h0021));
		prog.push_back(iInst(SB, 5'd2, 5'd4, 16'h0022));
		prog.push_back(iInst(SB, 5'd2, 5'd1, 16'h0023));
		prog.push_back(iInst(LW, 5'd2, 5'd5, 16'h0020));
		prog.push_back(iInst(SB, 5'd2, 5'd5, 16'h0045));
		prog.push_back(iInst(LW, 5'd2, 5'd6, 16'h0044));   // Merged with fill
		prog.push_back(iInst(LW, 5'd2, 5'd7, 16'h0000));
		prog.push_back(rInst(SUBU, 5'd7, 5'd6, 5'd8));
		startTest(prog.size());
		awaitResults();
		reportTest("storeLanes");
	endtask

	task automatic controlFlow();
		prog.delete();
		prog.push_back(iInst(ORI, 5'd0, 5'd1, 16'd5));
		prog.push_back(iInst(ORI, 5'd0, 5'd2, 16'd5));
		prog.push_back(iInst(BEQ, 5'd1, 5'd2, 16'd2));      // Taken to 5
		prog.push_back(iInst(ORI, 5'd0, 5'd3, 16'd1));
		prog.push_back(iInst(ORI, 5'd0, 5'd3, 16'd2));
		prog.push_back(iInst(BEQ, 5'd1, 5'd0, 16'd5));      // Not taken
		prog.push_back(iInst(ORI, 5'd0, 5'd4, 16'd3));
		prog.push_back(jInst(J, instAddr(10)));
		prog.push_back(iInst(ORI, 5'd0, 5'd6, 16'd4));
		prog.push_back(iInst(ORI, 5'd0, 5'd6, 16'd5));
		prog.push_back(jInst(JAL, instAddr(15)));
		prog.push_back(iInst(ORI, 5'd0, 5'd7, 16'd6));
		prog.push_back(iInst(ORI, 5'd0, 5'd8, 16'd7));      // Return lands here
		prog.push_back(jInst(J, instAddr(19)));
		prog.push_back(32'd0);
		// Subroutine
		prog.push_back(rInst(ADDU, 5'd31, 5'd0, 5'd10));
		prog.push_back(rInst(JR, 5'd10, 5'd0, 5'd0));
		prog.push_back(iInst(ORI, 5'd0, 5'd11, 16'd9));
		prog.push_back(iInst(ORI, 5'd0, 5'd11, 16'd10));
		startTest(19);
		awaitResults();
		reportTest("controlFlow");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lcgState = 32'h94a7299b;
		errors = 0;
		checks = 0;
		tests = 0;
		for (int i = 0; i < 1024; i++)
			imem[i] = 32'd0;

		resetIdle();
		aluChain();
		loadUse();
		storeLanes();
		controlFlow();

		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, u_dut.uAsserts.failCount);
		if (errors == 0 && u_dut.uAsserts.failCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* build.f */
common/mipsPkg.sv
decode/ctrl.sv
decode/grf.sv
src/ifu.sv
src/hazard.sv
src/alu.sv
src/mips.sv
verification/mips_asserts.sv
verification/tbMips.sv

/* Bender.yml */
package:
  name: mips

sources:
  - common/mipsPkg.sv
  - decode/ctrl.sv
  - decode/grf.sv
  - src/ifu.sv
  - src/hazard.sv
  - src/alu.sv
  - src/mips.sv
  - target: test
    files:
      - verification/mips_asserts.sv
      - verification/tbMips.sv
